//--- design/rv_pkg.sv
package rv_pkg;

    localparam int XLEN       = 32;          // Data path width
    localparam int REG_ADDR_W = 5;           // Register index width

    // RV32I major opcodes handled by this slice
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // Branch conditions in funct3
    localparam logic [2:0] F3_BEQ  = 3'h0;
    localparam logic [2:0] F3_BNE  = 3'h1;
    localparam logic [2:0] F3_BLT  = 3'h4;
    localparam logic [2:0] F3_BGE  = 3'h5;
    localparam logic [2:0] F3_BLTU = 3'h6;
    localparam logic [2:0] F3_BGEU = 3'h7;

    typedef enum logic [1:0] {
        ALU_OP_ITYPE  = 2'd0,
        ALU_OP_BRANCH = 2'd1,
        ALU_OP_RTYPE  = 2'd2,
        ALU_OP_STORE  = 2'd3
    } alu_op_t;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'h0,
        ALU_SUB  = 4'h1,
        ALU_SLL  = 4'h2,
        ALU_SLT  = 4'h3,
        ALU_SLTU = 4'h4,
        ALU_SRL  = 4'h5,
        ALU_SRA  = 4'h6,
        ALU_OR   = 4'h7,
        ALU_XOR  = 4'h8,
        ALU_AND  = 4'h9,
        ALU_ZERO = 4'hA                      // Result forced to zero
    } alu_ctrl_t;

    typedef enum logic [1:0] {
        IMM_I = 2'd0,
        IMM_S = 2'd1,
        IMM_B = 2'd2
    } imm_sel_t;

    typedef struct packed {
        alu_op_t  alu_op;
        logic     use_imm;                   // Operand b from immediate
        logic     reg_write;
        logic     is_store;
        logic     is_branch;
        imm_sel_t imm_sel;
    } ctrl_t;

    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
    } wb_t;

endpackage

//--- design/main_decoder.sv
`timescale 1ns/100ps

module main_decoder (
    input  logic [6:0]    opcode_i,     // Major opcode of the instruction
    output rv_pkg::ctrl_t ctrl_o,       // Datapath control bits
    output logic          illegal_o     // Unsupported opcode
);

    import rv_pkg::*;

    always_comb begin
        // Everything off unless a supported opcode matches
        ctrl_o.alu_op    = ALU_OP_ITYPE;
        ctrl_o.use_imm   = 1'b0;
        ctrl_o.reg_write = 1'b0;
        ctrl_o.is_store  = 1'b0;
        ctrl_o.is_branch = 1'b0;
        ctrl_o.imm_sel   = IMM_I;
        illegal_o        = 1'b0;

        case (opcode_i)
            OPC_OP: begin
                ctrl_o.alu_op    = ALU_OP_RTYPE;
                ctrl_o.reg_write = 1'b1;    // rs1 op rs2
            end

            OPC_OP_IMM: begin
                ctrl_o.alu_op    = ALU_OP_ITYPE;
                ctrl_o.use_imm   = 1'b1;
                ctrl_o.reg_write = 1'b1;
                ctrl_o.imm_sel   = IMM_I;
            end

            OPC_STORE: begin
                ctrl_o.alu_op   = ALU_OP_STORE;
                ctrl_o.use_imm  = 1'b1;     // Address is rs1 + imm
                ctrl_o.is_store = 1'b1;
                ctrl_o.imm_sel  = IMM_S;
            end

            OPC_BRANCH: begin
                // ALU compares rs1 with rs2, the target adder uses imm
                ctrl_o.alu_op    = ALU_OP_BRANCH;
                ctrl_o.is_branch = 1'b1;
                ctrl_o.imm_sel   = IMM_B;
            end

            default: begin
                illegal_o = 1'b1;           // Fetch, loads, jumps etc. not here
            end
        endcase
    end

endmodule

//--- design/alu_decoder.sv
`timescale 1ns/100ps

module alu_decoder (
    input  rv_pkg::alu_op_t   alu_op_i,       // Class from main decoder
    input  logic [2:0]        funct3_i,       // funct3 field
    input  logic [6:0]        funct7_i,       // funct7 field
    output rv_pkg::alu_ctrl_t alu_control_o,  // Operation for the ALU
    output logic              illegal_o       // Bad funct3/funct7 combination
);

    import rv_pkg::*;

    always_comb begin
        alu_control_o = ALU_ZERO;
        illegal_o     = 1'b0;

        case (alu_op_i)
            ALU_OP_ITYPE: begin
                case (funct3_i)
                    3'h0: alu_control_o = ALU_ADD;   // ADDI
                    3'h2: alu_control_o = ALU_SLT;   // SLTI
                    3'h3: alu_control_o = ALU_SLTU;  // SLTIU
                    3'h4: alu_control_o = ALU_XOR;   // XORI
                    3'h6: alu_control_o = ALU_OR;    // ORI
                    3'h7: alu_control_o = ALU_AND;   // ANDI
                    3'h1: begin
                        if (funct7_i == 7'h00) begin
                            alu_control_o = ALU_SLL; // SLLI
                        end else begin
                            illegal_o = 1'b1;
                        end
                    end
                    3'h5: begin
                        case (funct7_i)
                            7'h00:   alu_control_o = ALU_SRL;  // SRLI
                            7'h20:   alu_control_o = ALU_SRA;  // SRAI
                            default: illegal_o = 1'b1;
                        endcase
                    end
                    default: illegal_o = 1'b1;
                endcase
            end

            ALU_OP_BRANCH: begin
                case (funct3_i)
                    F3_BEQ, F3_BNE:   alu_control_o = ALU_SUB;   // Zero flag decides
                    F3_BLT, F3_BGE:   alu_control_o = ALU_SLT;
                    F3_BLTU, F3_BGEU: alu_control_o = ALU_SLTU;
                    default:          illegal_o = 1'b1;        // funct3 2 and 3
                endcase
            end

            ALU_OP_RTYPE: begin
                if (funct7_i == 7'h00) begin
                    case (funct3_i)
                        3'h0: alu_control_o = ALU_ADD;
                        3'h1: alu_control_o = ALU_SLL;
                        3'h2: alu_control_o = ALU_SLT;
                        3'h3: alu_control_o = ALU_SLTU;
                        3'h4: alu_control_o = ALU_XOR;
                        3'h5: alu_control_o = ALU_SRL;
                        3'h6: alu_control_o = ALU_OR;
                        3'h7: alu_control_o = ALU_AND;
                        default: illegal_o = 1'b1;
                    endcase
                end else if (funct7_i == 7'h20) begin
                    // Only SUB and SRA use the alternate encoding
                    case (funct3_i)
                        3'h0:    alu_control_o = ALU_SUB;
                        3'h5:    alu_control_o = ALU_SRA;
                        default: illegal_o = 1'b1;
                    endcase
                end else begin
                    illegal_o = 1'b1;                  // M extension and others
                end
            end

            ALU_OP_STORE: alu_control_o = ALU_ADD;     // Address generation

            default: illegal_o = 1'b1;
        endcase
    end

endmodule

//--- design/imm_gen.sv
`timescale 1ns/100ps

module imm_gen (
    input  logic [31:0]              instr_i,    // Raw instruction word
    input  rv_pkg::imm_sel_t         imm_sel_i,  // Immediate format
    output logic [rv_pkg::XLEN-1:0]  imm_o       // Sign-extended immediate
);

    import rv_pkg::*;

    logic [XLEN-1:0] imm_i_type;
    logic [XLEN-1:0] imm_s_type;
    logic [XLEN-1:0] imm_b_type;

    assign imm_i_type = {{(XLEN-12){instr_i[31]}}, instr_i[31:20]};
    assign imm_s_type = {{(XLEN-12){instr_i[31]}}, instr_i[31:25], instr_i[11:7]};

    // Branch offsets are in halfwords so bit 0 is always zero
    assign imm_b_type = {{(XLEN-12){instr_i[31]}}, instr_i[7], instr_i[30:25],
                         instr_i[11:8], 1'b0};

    always_comb begin
        case (imm_sel_i)
            IMM_S:   imm_o = imm_s_type;
            IMM_B:   imm_o = imm_b_type;
            default: imm_o = imm_i_type;
        endcase
    end

endmodule

//--- design/alu.sv
`timescale 1ns/100ps

module alu (
    input  logic [rv_pkg::XLEN-1:0] a_i,            // rs1 data
    input  logic [rv_pkg::XLEN-1:0] b_i,            // rs2 data or immediate
    input  rv_pkg::alu_ctrl_t       alu_control_i,  // Operation select
    output logic [rv_pkg::XLEN-1:0] result_o,
    output logic                    zero_o          // Result is all zero
);

    import rv_pkg::*;

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b_i[4:0];              // RV32 shifts use 5 bits
    assign lt_signed   = $signed(a_i) < $signed(b_i);
    assign lt_unsigned = a_i < b_i;

    always_comb begin
        case (alu_control_i)
            ALU_ADD:  result_o = a_i + b_i;
            ALU_SUB:  result_o = a_i - b_i;
            ALU_SLL:  result_o = a_i << shamt;
            ALU_SLT:  result_o = {{(XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU: result_o = {{(XLEN-1){1'b0}}, lt_unsigned};
            ALU_SRL:  result_o = a_i >> shamt;
            ALU_SRA:  result_o = $signed(a_i) >>> shamt;  // Keeps sign bit
            ALU_OR:   result_o = a_i | b_i;
            ALU_XOR:  result_o = a_i ^ b_i;
            ALU_AND:  result_o = a_i & b_i;
            default:  result_o = '0;                      // ALU_ZERO
        endcase
    end

    assign zero_o = (result_o == '0);

endmodule

//--- design/reg_file.sv
`timescale 1ns/100ps

module reg_file #(
    parameter int NUM_REGS = 32                          // 16 for RV32E
) (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rs2_addr_i,
    output logic [rv_pkg::XLEN-1:0]       rs1_data_o,
    output logic [rv_pkg::XLEN-1:0]       rs2_data_o,
    input  logic                          we_i,          // Write enable
    input  logic [rv_pkg::REG_ADDR_W-1:0] rd_addr_i,
    input  logic [rv_pkg::XLEN-1:0]       rd_data_i
);

    import rv_pkg::*;

    logic [XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && rd_addr_i != '0 && int'(rd_addr_i) < NUM_REGS) begin
            regs[rd_addr_i] <= rd_data_i;              // x0 never written
        end
    end

    // x0 and indices past NUM_REGS read as zero
    assign rs1_data_o = (rs1_addr_i == '0 || int'(rs1_addr_i) >= NUM_REGS) ?
                        '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0 || int'(rs2_addr_i) >= NUM_REGS) ?
                        '0 : regs[rs2_addr_i];

endmodule

//--- design/rv_exec_core.sv
`timescale 1ns/100ps

module rv_exec_core #(
    parameter int NUM_REGS = 32
) (
    input  logic                    clk_i,
    input  logic                    reset_i,
    input  logic                    instr_valid_i,    // One strobe per instruction
    input  logic [31:0]             instr_i,
    input  logic [rv_pkg::XLEN-1:0] pc_i,
    output rv_pkg::wb_t             wb_o,             // Register write-back
    output logic                    store_valid_o,
    output logic [rv_pkg::XLEN-1:0] store_addr_o,
    output logic [rv_pkg::XLEN-1:0] store_data_o,
    output logic                    branch_valid_o,
    output logic                    branch_taken_o,
    output logic [rv_pkg::XLEN-1:0] branch_target_o,
    output logic                    illegal_o
);

    import rv_pkg::*;

    ctrl_t           ctrl;
    alu_ctrl_t       alu_ctrl;
    logic            opc_illegal;
    logic            fn_illegal;
    logic            instr_illegal;
    logic            accept;                              // Valid and legal
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] alu_b;
    logic [XLEN-1:0] alu_result;
    logic            alu_zero;
    logic            take_branch;

    main_decoder i_main_decoder (
        .opcode_i  (instr_i[6:0]),
        .ctrl_o    (ctrl),
        .illegal_o (opc_illegal)
    );

    alu_decoder i_alu_decoder (
        .alu_op_i      (ctrl.alu_op),
        .funct3_i      (instr_i[14:12]),
        .funct7_i      (instr_i[31:25]),
        .alu_control_o (alu_ctrl),
        .illegal_o     (fn_illegal)
    );

    imm_gen i_imm_gen (
        .instr_i   (instr_i),
        .imm_sel_i (ctrl.imm_sel),
        .imm_o     (imm)
    );

    reg_file #(
        .NUM_REGS (NUM_REGS)
    ) i_reg_file (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .rs1_addr_i (instr_i[19:15]),
        .rs2_addr_i (instr_i[24:20]),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .we_i       (accept && ctrl.reg_write),           // rd of x0 dropped inside
        .rd_addr_i  (instr_i[11:7]),
        .rd_data_i  (alu_result)
    );

    assign alu_b = ctrl.use_imm ? imm : rs2_data;

    alu i_alu (
        .a_i           (rs1_data),
        .b_i           (alu_b),
        .alu_control_i (alu_ctrl),
        .result_o      (alu_result),
        .zero_o        (alu_zero)
    );

    assign instr_illegal = opc_illegal || fn_illegal;
    assign accept        = instr_valid_i && !instr_illegal;

    // SUB zero flag for equality, SLT/SLTU bit 0 for ordering
    always_comb begin
        case (instr_i[14:12])
            F3_BEQ:           take_branch = alu_zero;
            F3_BNE:           take_branch = !alu_zero;
            F3_BLT, F3_BLTU:  take_branch = alu_result[0];
            F3_BGE, F3_BGEU:  take_branch = !alu_result[0];
            default:          take_branch = 1'b0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wb_o            <= '0;
            store_valid_o   <= 1'b0;
            store_addr_o    <= '0;
            store_data_o    <= '0;
            branch_valid_o  <= 1'b0;
            branch_taken_o  <= 1'b0;
            branch_target_o <= '0;
            illegal_o       <= 1'b0;
        end else begin
            // Strobes last a single cycle
            wb_o.valid     <= accept && ctrl.reg_write;
            store_valid_o  <= accept && ctrl.is_store;
            branch_valid_o <= accept && ctrl.is_branch;
            illegal_o      <= instr_valid_i && instr_illegal;
            if (accept) begin
                wb_o.rd         <= instr_i[11:7];
                wb_o.data       <= alu_result;
                store_addr_o    <= alu_result;
                store_data_o    <= rs2_data;
                branch_taken_o  <= take_branch && ctrl.is_branch;
                branch_target_o <= pc_i + imm;
            end
        end
    end

endmodule

//--- bench/rv_exec_props.sv
`timescale 1ns/100ps

module rv_exec_props (
    input logic clk_i,
    input logic reset_i,
    input logic instr_valid_i,
    input logic wb_valid_i,
    input logic store_valid_i,
    input logic branch_valid_i,
    input logic illegal_i
);

    logic [3:0] strobes;

    assign strobes = {wb_valid_i, store_valid_i, branch_valid_i, illegal_i};

    a_single_strobe: assert property (@(posedge clk_i) $onehot0(strobes))
        else $error("more than one output strobe high in one cycle");

    // Each result belongs to the instruction strobed one cycle before
    a_strobe_cause: assert property (@(posedge clk_i) disable iff (reset_i)
        strobes != 4'b0000 |-> $past(instr_valid_i))
        else $error("output strobe without an instruction strobe one cycle earlier");

    a_reset_quiet: assert property (@(posedge clk_i)
        reset_i && $past(reset_i) |-> strobes == 4'b0000)
        else $error("output strobe high during reset");

endmodule

bind rv_exec_core rv_exec_props i_rv_exec_props (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .instr_valid_i  (instr_valid_i),
    .wb_valid_i     (wb_o.valid),
    .store_valid_i  (store_valid_o),
    .branch_valid_i (branch_valid_o),
    .illegal_i      (illegal_o)
);

//--- bench/rv_exec_tb.sv
`timescale 1ns/100ps

module rv_exec_tb;

    import rv_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int RESET_CYCLES = 2;
    // Itype, rtype, store, branch and illegal tests plus margin
    localparam int RUN_CYCLES = RESET_CYCLES + 80 + 20 + 10 + 30 + 10 + 50;
    localparam int K_NONE = 0;
    localparam int K_WB = 1;
    localparam int K_STORE = 2;
    localparam int K_BRANCH = 3;
    localparam int K_ILL = 4;

    logic            clk;
    logic            reset;
    logic            instr_valid;
    logic [31:0]     instr;
    logic [XLEN-1:0] pc;
    wb_t             wb;
    logic            store_valid;
    logic [XLEN-1:0] store_addr;
    logic [XLEN-1:0] store_data;
    logic            branch_valid;
    logic            branch_taken;
    logic [XLEN-1:0] branch_target;
    logic            illegal;

    logic [XLEN-1:0] model_regs [32];
    int              pend_kind = K_NONE;       // What the last strobe should produce
    logic [31:0]     pend_instr;
    logic [4:0]      pend_rd;
    logic [XLEN-1:0] pend_data;                // Write-back data or store address
    logic [XLEN-1:0] pend_sdata;
    logic            pend_taken;
    logic [XLEN-1:0] pend_target;
    string           test_name = "reset";
    int              seed = 84;

    rv_exec_core #(
        .NUM_REGS (32)
    ) i_rv_exec_core (
        .clk_i           (clk),
        .reset_i         (reset),
        .instr_valid_i   (instr_valid),
        .instr_i         (instr),
        .pc_i            (pc),
        .wb_o            (wb),
        .store_valid_o   (store_valid),
        .store_addr_o    (store_addr),
        .store_data_o    (store_data),
        .branch_valid_o  (branch_valid),
        .branch_taken_o  (branch_taken),
        .branch_target_o (branch_target),
        .illegal_o       (illegal)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] rtype_word(input logic [6:0] f7, input logic [4:0] rs2,
                                               input logic [4:0] rs1, input logic [2:0] f3,
                                               input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] itype_word(input logic [11:0] imm, input logic [4:0] rs1,
                                               input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] stype_word(input logic [11:0] imm, input logic [4:0] rs2,
                                               input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'h2, imm[4:0], OPC_STORE};   // SW
    endfunction

    function automatic logic [31:0] btype_word(input logic [12:0] off, input logic [4:0] rs2,
                                               input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic logic [XLEN-1:0] shift_right_arith(input logic [XLEN-1:0] v,
                                                          input logic [4:0] sh);
        return v[31] ? ~(~v >> sh) : v >> sh;  // Fill with ones for negatives
    endfunction

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped on first error");
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] exp,
                                   input logic [31:0] got);
        stop_run($sformatf("error in %s: instr %h %s expected %h actual %h",
                           test_name, pend_instr, what, exp, got));
    endtask

    task automatic check_outputs();
        logic [3:0] exp_strobes;
        logic [3:0] got_strobes;
        exp_strobes = 4'b0000;
        if (pend_kind != K_NONE) begin
            exp_strobes = 4'b0001 << (4 - pend_kind);   // wb, store, branch, illegal
        end
        got_strobes = {wb.valid, store_valid, branch_valid, illegal};
        assert (got_strobes == exp_strobes)
            else report_mismatch("strobes", {28'h0, exp_strobes}, {28'h0, got_strobes});
        if (pend_kind == K_WB) begin
            assert (wb.rd == pend_rd)
                else report_mismatch("wb rd", {27'h0, pend_rd}, {27'h0, wb.rd});
            assert (wb.data == pend_data) else report_mismatch("wb data", pend_data, wb.data);
        end else if (pend_kind == K_STORE) begin
            assert (store_addr == pend_data)
                else report_mismatch("store addr", pend_data, store_addr);
            assert (store_data == pend_sdata)
                else report_mismatch("store data", pend_sdata, store_data);
        end else if (pend_kind == K_BRANCH) begin
            assert (branch_taken == pend_taken)
                else report_mismatch("taken", {31'h0, pend_taken}, {31'h0, branch_taken});
            assert (branch_target == pend_target)
                else report_mismatch("target", pend_target, branch_target);
        end
    endtask

    // Reference behavior of one instruction, updates the model registers
    task automatic model_step(input logic [31:0] ins, input logic [XLEN-1:0] pc_val);
        logic [6:0]      opc;
        logic [2:0]      f3;
        logic [6:0]      f7;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] r;
        logic            ok;
        opc = ins[6:0];
        f3 = ins[14:12];
        f7 = ins[31:25];
        a = model_regs[ins[19:15]];
        b = model_regs[ins[24:20]];
        pend_instr = ins;
        pend_kind = K_ILL;
        if (opc == OPC_OP || opc == OPC_OP_IMM) begin
            if (opc == OPC_OP_IMM) begin
                b = {{20{ins[31]}}, ins[31:20]};
            end
            case (f3)
                3'h0: r = (opc == OPC_OP && f7 == 7'h20) ? a - b : a + b;
                3'h1: r = a << b[4:0];
                3'h2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                3'h3: r = (a < b) ? 32'd1 : 32'd0;
                3'h4: r = a ^ b;
                3'h5: r = f7[5] ? shift_right_arith(a, b[4:0]) : a >> b[4:0];
                3'h6: r = a | b;
                default: r = a & b;
            endcase
            if (opc == OPC_OP) begin
                ok = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'h0 || f3 == 3'h5));
            end else if (f3 == 3'h1) begin
                ok = (f7 == 7'h00);
            end else begin
                ok = (f3 != 3'h5) || f7 == 7'h00 || f7 == 7'h20;
            end
            if (ok) begin
                pend_kind = K_WB;
                pend_rd = ins[11:7];
                pend_data = r;
                if (ins[11:7] != 5'd0) begin
                    model_regs[ins[11:7]] = r;
                end
            end
        end else if (opc == OPC_STORE) begin
            pend_kind = K_STORE;
            pend_data = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
            pend_sdata = b;
        end else if (opc == OPC_BRANCH && f3 != 3'h2 && f3 != 3'h3) begin
            pend_kind = K_BRANCH;
            case (f3)
                3'h0: pend_taken = (a == b);
                3'h1: pend_taken = (a != b);
                3'h4: pend_taken = $signed(a) < $signed(b);
                3'h5: pend_taken = $signed(a) >= $signed(b);
                3'h6: pend_taken = a < b;
                default: pend_taken = a >= b;
            endcase
            pend_target = pc_val + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        end
    endtask

    // Outputs of the previous strobe are checked while this one is on the inputs
    task automatic issue(input logic [31:0] ins, input logic [XLEN-1:0] pc_val);
        @(posedge clk);
        instr_valid <= 1'b1;
        instr <= ins;
        pc <= pc_val;
        @(negedge clk);
        check_outputs();
        model_step(ins, pc_val);
    endtask

    task automatic drain();
        @(posedge clk);
        instr_valid <= 1'b0;
        @(negedge clk);
        check_outputs();
        pend_kind = K_NONE;
    endtask

    task automatic load_reg(input logic [4:0] rd, input logic [31:0] v);
        issue(itype_word(v[31:20], 5'd0, 3'h0, rd), '0);           // ADDI
        issue(itype_word(12'd11, rd, 3'h1, rd), '0);
        issue(itype_word({1'b0, v[19:9]}, rd, 3'h6, rd), '0);
        issue(itype_word(12'd9, rd, 3'h1, rd), '0);
        issue(itype_word({3'b0, v[8:0]}, rd, 3'h6, rd), '0);
    endtask

    task automatic itype_ops();
        logic [31:0] rnd;
        test_name = "itype";
        for (int r = 1; r <= 6; r++) begin
            rnd = $random(seed);
            if (r == 2) begin
                rnd[31] = 1'b1;                   // Negative source for SRAI
            end
            load_reg(5'(r), rnd);
        end
        for (int r = 1; r <= 4; r++) begin
            rnd = $random(seed);
            issue(itype_word(rnd[11:0], 5'(r), 3'h0, 5'd7), '0);
            issue(itype_word(rnd[23:12], 5'(r), 3'h2, 5'd7), '0);
            issue(itype_word(rnd[11:0], 5'(r), 3'h3, 5'd8), '0);
            issue(itype_word(12'hfff, 5'(r), 3'h3, 5'd8), '0);      // SLTIU against -1
            issue(itype_word(rnd[23:12], 5'(r), 3'h4, 5'd9), '0);
            issue(itype_word(rnd[11:0], 5'(r), 3'h6, 5'd9), '0);
            issue(itype_word(rnd[23:12], 5'(r), 3'h7, 5'd9), '0);
            issue(itype_word({7'h00, rnd[28:24]}, 5'(r), 3'h1, 5'd7), '0);
            issue(itype_word({7'h00, rnd[28:24]}, 5'(r), 3'h5, 5'd8), '0);
            issue(itype_word({7'h20, rnd[28:24]}, 5'(r), 3'h5, 5'd9), '0);
        end
        drain();
    endtask

    task automatic rtype_chain();
        logic [2:0]  f3s [10] = '{3'h0, 3'h0, 3'h1, 3'h2, 3'h3, 3'h4, 3'h5, 3'h5, 3'h6, 3'h7};
        logic [6:0]  f7s [10] = '{7'h00, 7'h20, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00, 7'h20,
                                  7'h00, 7'h00};
        logic [31:0] rnd;
        test_name = "rtype";
        issue(itype_word(12'h0, 5'd1, 3'h0, 5'd10), '0);
        for (int k = 0; k < 10; k++) begin
            rnd = $random(seed);
            issue(rtype_word(f7s[k], 5'(1 + rnd[7:0] % 6), 5'd10, f3s[k], 5'd10), '0);
        end
        issue(rtype_word(7'h00, 5'd2, 5'd1, 3'h0, 5'd0), '0);       // Result dropped
        issue(rtype_word(7'h00, 5'd0, 5'd0, 3'h0, 5'd11), '0);      // x0 still zero
        drain();
    endtask

    task automatic store_address();
        logic [31:0] rnd;
        test_name = "store";
        for (int k = 0; k < 6; k++) begin
            rnd = $random(seed);
            issue(stype_word(rnd[11:0], 5'(1 + rnd[15:12] % 7), 5'(1 + rnd[19:16] % 7)), '0);
        end
        drain();
    endtask

    task automatic branch_conditions();
        logic [2:0]  conds [6] = '{3'h0, 3'h1, 3'h4, 3'h5, 3'h6, 3'h7};
        logic [4:0]  rs1s [3] = '{5'd13, 5'd12, 5'd13};  // Equal, signed less, unsigned less
        logic [4:0]  rs2s [3] = '{5'd13, 5'd13, 5'd12};
        logic [31:0] rnd;
        logic [31:0] pcv;
        test_name = "branch";
        issue(itype_word(12'hffb, 5'd0, 3'h0, 5'd12), '0);          // x12 = -5
        issue(itype_word(12'h003, 5'd0, 3'h0, 5'd13), '0);
        for (int p = 0; p < 3; p++) begin
            for (int c = 0; c < 6; c++) begin
                rnd = $random(seed);
                pcv = $random(seed);
                issue(btype_word({rnd[11:0], 1'b0}, rs2s[p], rs1s[p], conds[c]),
                      {pcv[31:2], 2'b00});
            end
        end
        drain();
    endtask

    task automatic illegal_encodings();
        test_name = "illegal";
        issue({12'h5a5, 5'd2, 3'h2, 5'd1, 7'b0000011}, '0);           // Load opcode
        issue(rtype_word(7'h01, 5'd3, 5'd2, 3'h0, 5'd1), '0);
        issue(itype_word({7'h20, 5'd3}, 5'd2, 3'h1, 5'd1), '0);
        issue(btype_word(13'h10, 5'd2, 5'd1, 3'h2), '0);
        issue(itype_word(12'h0, 5'd1, 3'h0, 5'd14), '0);            // x1 must be unchanged
        drain();
    endtask

    initial begin
        #(RUN_CYCLES * CLK_PERIOD);
        stop_run("watchdog expired before all tests finished");
    end

    initial begin
        reset = 1'b1;
        instr_valid = 1'b0;
        instr = '0;
        pc = '0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        itype_ops();
        rtype_chain();
        store_address();
        branch_conditions();
        illegal_encodings();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

//--- vlog.f
design/rv_pkg.sv
design/main_decoder.sv
design/alu_decoder.sv
design/imm_gen.sv
design/alu.sv
design/reg_file.sv
design/rv_exec_core.sv
bench/rv_exec_props.sv
bench/rv_exec_tb.sv

//--- run.sh
#!/bin/sh
# Builds and runs the rv_exec_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module rv_exec_tb -o rv_exec_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/rv_exec_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit "$status"
fi

exit 0
